// File: Makefile
VERILATOR  ?= verilator
TOP        := matmul_tb
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal -Mdir $(OBJ_DIR)
PASS_TEXT  := test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

# pass only when the testbench prints the pass line
sim: $(OBJ_DIR)/V$(TOP)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: design/mac_array.sv
`timescale 1ns/1ns

// output-stationary grid
// a enters on the left edge and moves right, b enters on top and moves down
module mac_array (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           clear,
  input  matmul_types_pkg::operand_row_t a_skewed,
  input  matmul_types_pkg::operand_row_t b_skewed,
  output matmul_types_pkg::result_t      sums [matmul_cfg_pkg::dim*matmul_cfg_pkg::dim]
);

  // forwarding registers between neighbours
  // the right column and bottom row have no one to pass to
  matmul_types_pkg::elem_t a_q [matmul_cfg_pkg::dim][matmul_cfg_pkg::dim-1];
  matmul_types_pkg::elem_t b_q [matmul_cfg_pkg::dim-1][matmul_cfg_pkg::dim];

  // one accumulator per cell
  matmul_types_pkg::result_t acc [matmul_cfg_pkg::dim][matmul_cfg_pkg::dim];

  for (genvar i = 0; i < matmul_cfg_pkg::dim; i++) begin : g_row
    for (genvar j = 0; j < matmul_cfg_pkg::dim; j++) begin : g_col
      matmul_types_pkg::elem_t   a_in;
      matmul_types_pkg::elem_t   b_in;
      matmul_types_pkg::result_t prod;

      // a from the left edge or the cell to the left
      if (j == 0) begin : g_a_edge
        assign a_in = a_skewed[i];
      end else begin : g_a_fwd
        assign a_in = a_q[i][j-1];
      end

      // b from the top edge or the cell above
      if (i == 0) begin : g_b_edge
        assign b_in = b_skewed[j];
      end else begin : g_b_fwd
        assign b_in = b_q[i-1][j];
      end

      // operands zero-extended so the product is exact
      assign prod = matmul_types_pkg::result_t'(a_in) * matmul_types_pkg::result_t'(b_in);

      always_ff @(posedge clk) begin
        if (reset || clear) begin
          acc[i][j] <= '0;
        end else begin
          acc[i][j] <= acc[i][j] + prod;
        end
      end

      if (j < matmul_cfg_pkg::dim - 1) begin : g_a_reg
        always_ff @(posedge clk) begin
          if (reset || clear) begin
            a_q[i][j] <= '0;
          end else begin
            a_q[i][j] <= a_in;
          end
        end
      end

      if (i < matmul_cfg_pkg::dim - 1) begin : g_b_reg
        always_ff @(posedge clk) begin
          if (reset || clear) begin
            b_q[i][j] <= '0;
          end else begin
            b_q[i][j] <= b_in;
          end
        end
      end

      // row-major result order
      assign sums[i*matmul_cfg_pkg::dim + j] = acc[i][j];
    end
  end

endmodule

// File: design/matmul_cfg_pkg.sv
package matmul_cfg_pkg;

  // matrix order and element widths
  localparam int dim          = 4;
  localparam int elem_width   = 8;

  // 4 products of 255*255 stay below 2**20
  localparam int result_width = 20;

  // operand and result memories
  localparam int addr_width   = 4;
  localparam int mem_depth    = 16;

  // run schedule in counter steps
  // memory word k reaches the array at step k+1 and cell (i,j) takes its
  // last product at step 4+i+j, so row 0 is final from step 2*dim on
  localparam int capture_step = 2 * dim;

  // last row is captured at capture_step+dim-1 and written one step later
  localparam int run_cycles   = capture_step + dim + 1;

endpackage

// File: design/matmul_top.sv
`timescale 1ns/1ns

module matmul_top (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           load_a,
  input  logic                           load_b,
  input  matmul_types_pkg::addr_t        host_addr,
  input  matmul_types_pkg::operand_row_t host_wdata,
  input  logic                           rd_en,
  output matmul_types_pkg::result_row_t  rd_data,
  output logic                           rd_valid,
  input  logic                           start,
  output logic                           done
);

  matmul_types_pkg::step_t        step;
  logic                           clear;
  matmul_types_pkg::operand_row_t a_skewed;
  matmul_types_pkg::operand_row_t b_skewed;
  matmul_types_pkg::result_t      sums [matmul_cfg_pkg::dim*matmul_cfg_pkg::dim];

  // operand memories, run control and skew
  operand_feeder feeder_i (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .load_a     (load_a),
    .load_b     (load_b),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .step       (step),
    .clear      (clear),
    .done       (done),
    .a_skewed   (a_skewed),
    .b_skewed   (b_skewed)
  );

  // multiply-accumulate grid
  mac_array array_i (
    .clk      (clk),
    .reset    (reset),
    .clear    (clear),
    .a_skewed (a_skewed),
    .b_skewed (b_skewed),
    .sums     (sums)
  );

  // result memory and host readback
  result_collector collector_i (
    .clk       (clk),
    .reset     (reset),
    .step      (step),
    .sums      (sums),
    .rd_en     (rd_en),
    .host_addr (host_addr),
    .rd_data   (rd_data),
    .rd_valid  (rd_valid)
  );

endmodule

// File: design/matmul_types_pkg.sv
package matmul_types_pkg;

  // single operand element
  typedef logic [matmul_cfg_pkg::elem_width-1:0] elem_t;

  // single accumulated element
  typedef logic [matmul_cfg_pkg::result_width-1:0] result_t;

  // one memory word of operands, element 0 in the low bits
  typedef elem_t [matmul_cfg_pkg::dim-1:0] operand_row_t;

  // one memory word of results, element 0 in the low bits
  typedef result_t [matmul_cfg_pkg::dim-1:0] result_row_t;

  // memory word address
  typedef logic [matmul_cfg_pkg::addr_width-1:0] addr_t;

  // run step counter
  // wide enough for run_cycles with room to spare
  typedef logic [5:0] step_t;

endpackage

// File: design/operand_feeder.sv
`timescale 1ns/1ns

module operand_feeder (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           start,
  input  logic                           load_a,
  input  logic                           load_b,
  input  matmul_types_pkg::addr_t        host_addr,
  input  matmul_types_pkg::operand_row_t host_wdata,
  output matmul_types_pkg::step_t        step,
  output logic                           clear,
  output logic                           done,
  output matmul_types_pkg::operand_row_t a_skewed,
  output matmul_types_pkg::operand_row_t b_skewed
);

  matmul_types_pkg::addr_t        run_addr;
  matmul_types_pkg::addr_t        mem_addr;
  matmul_types_pkg::operand_row_t a_word;
  matmul_types_pkg::operand_row_t b_word;
  matmul_types_pkg::operand_row_t a_live;
  matmul_types_pkg::operand_row_t b_live;
  logic                           fetch_live;

  // idle whenever start is low
  assign clear = !start;

  // run counter, holds at run_cycles once done is up
  always_ff @(posedge clk) begin
    if (reset || clear) begin
      step <= '0;
      done <= 1'b0;
    end else if (step == matmul_types_pkg::step_t'(matmul_cfg_pkg::run_cycles)) begin
      done <= 1'b1;
    end else begin
      step <= step + 1'b1;
    end
  end

  // words 0..dim-1 in order, then park on the top word
  assign run_addr = (step < matmul_cfg_pkg::dim) ?
                    matmul_types_pkg::addr_t'(step) :
                    matmul_types_pkg::addr_t'(matmul_cfg_pkg::mem_depth - 1);
  assign mem_addr = start ? run_addr : host_addr;

  // marks the cycle in which a fetched word sits on the memory output
  always_ff @(posedge clk) begin
    if (reset) begin
      fetch_live <= 1'b0;
    end else begin
      fetch_live <= start && (step < matmul_cfg_pkg::dim);
    end
  end

  row_ram #(.row_t(matmul_types_pkg::operand_row_t)) a_ram (
    .clk   (clk),
    .addr  (mem_addr),
    .wdata (host_wdata),
    .we    (load_a),
    .rdata (a_word)
  );

  row_ram #(.row_t(matmul_types_pkg::operand_row_t)) b_ram (
    .clk   (clk),
    .addr  (mem_addr),
    .wdata (host_wdata),
    .we    (load_b),
    .rdata (b_word)
  );

  // parked word is not part of the matrix, feed zeros instead
  assign a_live = fetch_live ? a_word : '0;
  assign b_live = fetch_live ? b_word : '0;

  // element j is delayed j cycles to form the diagonal wavefront
  for (genvar j = 0; j < matmul_cfg_pkg::dim; j++) begin : g_skew
    if (j == 0) begin : g_direct
      assign a_skewed[j] = a_live[j];
      assign b_skewed[j] = b_live[j];
    end else begin : g_delay
      matmul_types_pkg::elem_t a_dly [j];
      matmul_types_pkg::elem_t b_dly [j];

      always_ff @(posedge clk) begin
        if (reset || clear) begin
          for (int d = 0; d < j; d++) begin
            a_dly[d] <= '0;
            b_dly[d] <= '0;
          end
        end else begin
          a_dly[0] <= a_live[j];
          b_dly[0] <= b_live[j];
          for (int d = 1; d < j; d++) begin
            a_dly[d] <= a_dly[d-1];
            b_dly[d] <= b_dly[d-1];
          end
        end
      end

      assign a_skewed[j] = a_dly[j-1];
      assign b_skewed[j] = b_dly[j-1];
    end
  end

  // host may only load while idle
  a_no_load_in_run: assert property (@(posedge clk) disable iff (reset)
    start |-> !(load_a || load_b));

  // done only after start has been held for the whole run
  a_done_after_start: assert property (@(posedge clk) disable iff (reset)
    done |-> $past(start, matmul_cfg_pkg::run_cycles + 1));

endmodule

// File: design/result_collector.sv
`timescale 1ns/1ns

module result_collector (
  input  logic                          clk,
  input  logic                          reset,
  input  matmul_types_pkg::step_t       step,
  input  matmul_types_pkg::result_t     sums [matmul_cfg_pkg::dim*matmul_cfg_pkg::dim],
  input  logic                          rd_en,
  input  matmul_types_pkg::addr_t       host_addr,
  output matmul_types_pkg::result_row_t rd_data,
  output logic                          rd_valid
);

  logic                          cap_hit;
  matmul_types_pkg::addr_t       cap_idx;
  matmul_types_pkg::result_row_t cap_row;
  matmul_types_pkg::addr_t       cap_addr;
  logic                          cap_we;
  matmul_types_pkg::addr_t       host_addr_q;
  logic                          rd_en_q;
  matmul_types_pkg::addr_t       c_addr;

  // array row i is final from step capture_step+i on
  assign cap_hit = (step >= matmul_cfg_pkg::capture_step) &&
                   (step < matmul_cfg_pkg::capture_step + matmul_cfg_pkg::dim);
  assign cap_idx = matmul_types_pkg::addr_t'(step - matmul_cfg_pkg::capture_step);

  always_ff @(posedge clk) begin
    if (reset) begin
      cap_we   <= 1'b0;
      rd_en_q  <= 1'b0;
      rd_valid <= 1'b0;
    end else begin
      cap_we   <= cap_hit;
      rd_en_q  <= rd_en;
      rd_valid <= rd_en_q;
    end
  end

  // captured row and its target word
  always_ff @(posedge clk) begin
    host_addr_q <= host_addr;
    if (cap_hit) begin
      cap_addr <= cap_idx;
      for (int j = 0; j < matmul_cfg_pkg::dim; j++) begin
        cap_row[j] <= sums[int'(cap_idx)*matmul_cfg_pkg::dim + j];
      end
    end
  end

  // capture write owns the port, host reads otherwise
  assign c_addr = cap_we ? cap_addr : host_addr_q;

  row_ram #(.row_t(matmul_types_pkg::result_row_t)) c_ram (
    .clk   (clk),
    .addr  (c_addr),
    .wdata (cap_row),
    .we    (cap_we),
    .rdata (rd_data)
  );

  // host reads must stay clear of the capture window
  a_no_read_in_capture: assert property (@(posedge clk) disable iff (reset)
    cap_hit |-> !rd_en);

endmodule

// File: design/row_ram.sv
`timescale 1ns/1ns

// single-port memory, one row per word
// write and read share the address; a read during a write returns old data
module row_ram #(
  parameter type row_t = matmul_types_pkg::operand_row_t
) (
  input  logic                    clk,
  input  matmul_types_pkg::addr_t addr,
  input  row_t                    wdata,
  input  logic                    we,
  output row_t                    rdata
);

  row_t mem [matmul_cfg_pkg::mem_depth];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    // registered read
    rdata <= mem[addr];
  end

endmodule

// File: dv/matmul_tb.sv
`timescale 1ns/1ns

module matmul_tb;

  localparam int n          = matmul_cfg_pkg::dim;
  localparam int wait_limit = 200;

  logic                           clk;
  logic                           reset;
  logic                           load_a;
  logic                           load_b;
  matmul_types_pkg::addr_t        host_addr;
  matmul_types_pkg::operand_row_t host_wdata;
  logic                           rd_en;
  matmul_types_pkg::result_row_t  rd_data;
  logic                           rd_valid;
  logic                           start;
  logic                           done;

  // operand matrices and expected product rows
  matmul_types_pkg::elem_t       a_mat [n][n];
  matmul_types_pkg::elem_t       b_mat [n][n];
  matmul_types_pkg::result_row_t model_rows [matmul_cfg_pkg::mem_depth];

  // host view of the two-cycle read
  matmul_types_pkg::addr_t       read_addr_d1;
  matmul_types_pkg::addr_t       read_addr_d2;
  logic                          rd_en_d1;
  logic                          rd_en_d2;
  matmul_types_pkg::result_row_t expected_rd;

  // edges seen with start high in the current run
  int   held_cycles;
  logic done_due;

  matmul_top dut_i (
    .clk        (clk),
    .reset      (reset),
    .load_a     (load_a),
    .load_b     (load_b),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .rd_en      (rd_en),
    .rd_data    (rd_data),
    .rd_valid   (rd_valid),
    .start      (start),
    .done       (done)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    if (reset) begin
      rd_en_d1    <= 1'b0;
      rd_en_d2    <= 1'b0;
      held_cycles <= 0;
    end else begin
      rd_en_d1    <= rd_en;
      rd_en_d2    <= rd_en_d1;
      held_cycles <= start ? held_cycles + 1 : 0;
    end
    read_addr_d1 <= host_addr;
    read_addr_d2 <= read_addr_d1;
  end

  assign expected_rd = model_rows[read_addr_d2];
  // done is due once run_cycles edges have passed the first start edge
  assign done_due    = held_cycles > matmul_cfg_pkg::run_cycles;

  task automatic report_mismatch(input string name, input logic [127:0] expected,
                                 input logic [127:0] actual);
    $display("error at %0t ns: %s expected %0h actual %0h", $time, name, expected, actual);
    $display("test failed");
    $fatal(1, "%s check stopped the run", name);
  endtask

  task automatic report_failure(input string what);
    $display("%s at %0t ns", what, $time);
    $display("test failed");
    $fatal(1, "%s", what);
  endtask

  // result rows against the model
  a_rd_data: assert property (@(posedge clk) disable iff (reset)
    rd_valid |-> rd_data == expected_rd)
    else report_mismatch("rd_data", 128'($sampled(expected_rd)), 128'($sampled(rd_data)));

  // rd_valid exactly two cycles after rd_en, never otherwise
  a_rd_valid: assert property (@(posedge clk) disable iff (reset)
    rd_valid == rd_en_d2)
    else report_mismatch("rd_valid", 128'($sampled(rd_en_d2)), 128'($sampled(rd_valid)));

  // done rises after the fixed run length and holds while start does
  a_done_run: assert property (@(posedge clk) disable iff (reset)
    start |-> done == done_due)
    else report_mismatch("done", 128'($sampled(done_due)), 128'($sampled(done)));

  // done is gone one edge after start falls
  a_done_idle: assert property (@(posedge clk) disable iff (reset)
    !$past(start) |-> !done)
    else report_mismatch("done", '0, 128'($sampled(done)));

  function automatic void fill_identity_random();
    for (int i = 0; i < n; i++) begin
      for (int k = 0; k < n; k++) begin
        a_mat[i][k] = (i == k) ? 8'd1 : 8'd0;
        b_mat[i][k] = matmul_types_pkg::elem_t'($urandom());
      end
    end
  endfunction

  function automatic void fill_random();
    for (int i = 0; i < n; i++) begin
      for (int k = 0; k < n; k++) begin
        a_mat[i][k] = matmul_types_pkg::elem_t'($urandom());
        b_mat[i][k] = matmul_types_pkg::elem_t'($urandom());
      end
    end
  endfunction

  function automatic void fill_constant(input matmul_types_pkg::elem_t value);
    for (int i = 0; i < n; i++) begin
      for (int k = 0; k < n; k++) begin
        a_mat[i][k] = value;
        b_mat[i][k] = value;
      end
    end
  endfunction

  // c[i][j] = sum over k of a[i][k] * b[k][j]
  task automatic build_model();
    int sum;
    for (int i = 0; i < matmul_cfg_pkg::mem_depth; i++) begin
      model_rows[i] = '0;
    end
    for (int i = 0; i < n; i++) begin
      for (int j = 0; j < n; j++) begin
        sum = 0;
        for (int k = 0; k < n; k++) begin
          sum += int'(a_mat[i][k]) * int'(b_mat[k][j]);
        end
        model_rows[i][j] = matmul_types_pkg::result_t'(sum);
      end
    end
  endtask

  // word k takes column k of A
  task automatic load_a_columns();
    for (int k = 0; k < n; k++) begin
      host_addr = matmul_types_pkg::addr_t'(k);
      for (int i = 0; i < n; i++) begin
        host_wdata[i] = a_mat[i][k];
      end
      load_a = 1'b1;
      @(negedge clk);
    end
    load_a = 1'b0;
  endtask

  // word k takes row k of B
  task automatic load_b_rows();
    for (int k = 0; k < n; k++) begin
      host_addr = matmul_types_pkg::addr_t'(k);
      for (int j = 0; j < n; j++) begin
        host_wdata[j] = b_mat[k][j];
      end
      load_b = 1'b1;
      @(negedge clk);
    end
    load_b = 1'b0;
  endtask

  task automatic run_product(input int extra_hold);
    int waited;
    waited = 0;
    start  = 1'b1;
    @(negedge clk);
    while (!done) begin
      if (waited == wait_limit) begin
        report_failure("timeout waiting for done");
      end
      waited++;
      @(negedge clk);
    end
    // keep start up a while so done has to hold
    repeat (extra_hold) @(negedge clk);
    start = 1'b0;
    @(negedge clk);
  endtask

  task automatic read_rows();
    int waited;
    for (int i = 0; i < n; i++) begin
      host_addr = matmul_types_pkg::addr_t'(i);
      rd_en     = 1'b1;
      @(negedge clk);
      rd_en  = 1'b0;
      waited = 0;
      while (!rd_valid) begin
        if (waited == wait_limit) begin
          report_failure("timeout waiting for rd_valid");
        end
        waited++;
        @(negedge clk);
      end
    end
  endtask

  task automatic multiply_and_check(input int extra_hold);
    load_a_columns();
    load_b_rows();
    build_model();
    run_product(extra_hold);
    read_rows();
  endtask

  initial begin
    void'($urandom(32'hb235_8938));
    clk        = 1'b0;
    reset      = 1'b1;
    load_a     = 1'b0;
    load_b     = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    rd_en      = 1'b0;
    start      = 1'b0;
    for (int i = 0; i < matmul_cfg_pkg::mem_depth; i++) begin
      model_rows[i] = '0;
    end
    repeat (4) @(negedge clk);
    reset = 1'b0;

    // quiet period, done and rd_valid must stay low
    repeat (6) @(negedge clk);

    fill_identity_random();
    multiply_and_check(1);

    for (int r = 0; r < 20; r++) begin
      fill_random();
      multiply_and_check(int'($urandom_range(3)));
    end

    // largest operands, every entry 4*255*255
    fill_constant(8'hff);
    multiply_and_check(3);

    // back-to-back run must not see the old sums
    fill_random();
    multiply_and_check(0);

    // let the last read reach its check
    @(negedge clk);

    $display("test passed");
    $finish;
  end

endmodule

// File: filelist.f
design/matmul_cfg_pkg.sv
design/matmul_types_pkg.sv
design/row_ram.sv
design/operand_feeder.sv
design/mac_array.sv
design/result_collector.sv
design/matmul_top.sv
dv/matmul_tb.sv
